// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wall -Wno-fatal
TOP      = cam_stream_tb
FILELIST = cam_stream.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM) and run $(TOP)"
	@echo "  clean  remove build output"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/cam_stream_properties.sv
`timescale 1ns/1ps
`default_nettype none

module cam_stream_properties (
    input logic                core_clk,
    input logic                sys_reset,
    input logic                stall_i,
    input cmd_pkg::host_byte_t byte_o,
    input logic                valid_o,
    input logic                overflow_o
);

    // a stalled byte stays on the bus until it transfers
    hold_under_stall: assert property (@(posedge core_clk) disable iff (sys_reset)
        valid_o && stall_i |=> valid_o && $stable(byte_o))
        else $error("output byte or valid changed while stalled");

    // overflow is sticky
    overflow_sticky: assert property (@(posedge core_clk) disable iff (sys_reset)
        overflow_o |=> overflow_o)
        else $error("overflow flag dropped without reset");

    idle_after_reset: assert property (@(posedge core_clk)
        sys_reset |=> !valid_o)
        else $error("output valid high in the cycle after reset");

endmodule

bind frame_serializer cam_stream_properties u_cam_stream_properties (
    .core_clk  (core_clk),
    .sys_reset (sys_reset),
    .stall_i   (stall_i),
    .byte_o    (byte_o),
    .valid_o   (valid_o),
    .overflow_o(overflow_o)
);

`default_nettype wire

// File: bench/cam_stream_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cam_stream_config.svh"

module cam_stream_tb;
    import cmd_pkg::*;
    import pix_pkg::*;

    localparam real         DRIVE_DLY     = 0.5;
    localparam int          RESET_CYCLES  = 4;
    localparam int          CMD_SETTLE    = 3;
    localparam int          IDLE_CYCLES   = 40;
    localparam int          DRAIN_TIMEOUT = 4000;
    localparam int          FIELDS        = 5;
    localparam int          MAX_RECORDS   = 32;
    localparam int          STALL_ALL     = 8;
    localparam int          RESET_COL     = 4;
    localparam int          RESET_ROW     = 3;
    localparam logic [15:0] MODE_KEEP     = 16'h0000;
    localparam logic [15:0] MODE_SET      = 16'h0001;
    localparam logic [15:0] MODE_UNKNOWN  = 16'h0002;
    localparam logic [15:0] MODE_END      = 16'h000F;
    localparam logic [15:0] ADDR_UNUSED   = 16'h0012;
    localparam logic [63:0] MAGIC         = "BIVFRAME";

    logic       core_clk = 1'b0;
    logic       sys_reset;
    host_byte_t host_byte_i;
    logic       host_valid_i;
    pixel_t     pix_i;
    logic       pix_valid_i;
    logic       pix_sof_i;
    logic       out_stall_i = 1'b0;
    host_byte_t out_byte_o;
    logic       out_valid_o;
    logic       overflow_o;

    logic [15:0] vec_mem [0:MAX_RECORDS*FIELDS-1];
    host_byte_t  exp_q [$];
    integer      seed = 52;
    int          cur_density = 0;
    int          error_count = 0;
    int          bytes_seen = 0;
    int          model_col;
    int          model_row;
    logic        overflow_seen = 1'b0;
    int          rec;
    logic        done;
    logic [15:0] mode;

    cam_stream_top u_cam_stream_top (
        .core_clk    (core_clk),
        .sys_reset   (sys_reset),
        .host_byte_i (host_byte_i),
        .host_valid_i(host_valid_i),
        .pix_i       (pix_i),
        .pix_valid_i (pix_valid_i),
        .pix_sof_i   (pix_sof_i),
        .out_stall_i (out_stall_i),
        .out_byte_o  (out_byte_o),
        .out_valid_o (out_valid_o),
        .overflow_o  (overflow_o)
    );

    always #2 core_clk = ~core_clk;

    ////////////////////////////////////////////////////////////////////////////
    // checks

    task automatic stop_with_failure();
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_byte(input host_byte_t actual, input host_byte_t expected,
                              input string what);
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH at %0t ns: %s is 0x%02h, expected 0x%02h",
                     $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    task automatic next_cycle();
        @(posedge core_clk);
        #(DRIVE_DLY);
    endtask

    // first byte on the link is the top of {addr, data}
    task automatic send_command(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] word;
        word = {addr, data};
        for (int i = 5; i >= 0; i--) begin
            host_byte_i  = word[i*8 +: 8];
            host_valid_i = 1'b1;
            next_cycle();
        end
        host_valid_i = 1'b0;
    endtask

    function automatic pixel_t raw_pixel(input int seed_val, input int r, input int c);
        return pixel_t'((seed_val + r * `CFG_RAW_WIDTH + c) % 256);
    endfunction

    task automatic stream_frame(input int seed_val);
        for (int r = 0; r < `CFG_RAW_HEIGHT; r++) begin
            for (int c = 0; c < `CFG_RAW_WIDTH; c++) begin
                pix_i       = raw_pixel(seed_val, r, c);
                pix_valid_i = 1'b1;
                pix_sof_i   = (r == 0) && (c == 0);
                next_cycle();
            end
        end
        pix_valid_i = 1'b0;
        pix_sof_i   = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model

    task automatic push_header();
        for (int i = 0; i < 8; i++) begin
            exp_q.push_back(MAGIC[63 - 8*i -: 8]);
        end
    endtask

    // only the first FIFO-depth pixels survive while the output is held
    task automatic predict_frame(input int seed_val, inout int kept);
        for (int r = 0; r < `CFG_RAW_HEIGHT; r++) begin
            for (int c = 0; c < `CFG_RAW_WIDTH; c++) begin
                if (c >= model_col && c < model_col + `CFG_ROI_WIDTH &&
                    r >= model_row && r < model_row + `CFG_ROI_HEIGHT) begin
                    if (kept < `CFG_FIFO_DEPTH) begin
                        if (c == model_col && r == model_row) begin
                            push_header();
                        end
                        exp_q.push_back(raw_pixel(seed_val, r, c));
                    end
                    kept++;
                end
            end
        end
    endtask

    task automatic apply_commands(input logic [15:0] cmd_mode, input logic [15:0] col,
                                  input logic [15:0] row);
        if (cmd_mode == MODE_SET) begin
            send_command(`CFG_ADDR_ROI_COL, {16'h0000, col});
            send_command(`CFG_ADDR_ROI_ROW, {16'h0000, row});
            model_col = int'(col);
            model_row = int'(row);
        end else if (cmd_mode == MODE_UNKNOWN) begin
            // decoder must ignore this one
            send_command(ADDR_UNUSED, {16'h0000, col});
        end
        // register update lands two cycles after the last byte
        repeat (CMD_SETTLE) next_cycle();
    endtask

    task automatic wait_drained(input string what);
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0) begin
            if (cycles >= DRAIN_TIMEOUT) begin
                $display("timeout: %0d bytes of %s never arrived", exp_q.size(), what);
                stop_with_failure();
            end else begin
                next_cycle();
                cycles++;
            end
        end
    endtask

    task automatic run_record(input logic [15:0] cmd_mode, input logic [15:0] col,
                              input logic [15:0] row, input logic [15:0] seed_val,
                              input logic [15:0] density);
        int kept;
        int frames;
        cur_density = int'(density);
        apply_commands(cmd_mode, col, row);
        frames = (cur_density >= STALL_ALL) ? 2 : 1;
        kept = 0;
        for (int f = 0; f < frames; f++) begin
            predict_frame(int'(seed_val), kept);
        end
        for (int f = 0; f < frames; f++) begin
            stream_frame(int'(seed_val));
        end
        if (cur_density >= STALL_ALL) begin
            check_flag(overflow_o, 1'b1, "overflow with output held");
            overflow_seen = 1'b1;
            cur_density = 0;
        end
        wait_drained("frame output");
        check_flag(overflow_o, overflow_seen, "overflow after frame");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // output side

    always @(posedge core_clk) begin
        #(DRIVE_DLY);
        out_stall_i = (($unsigned($random(seed)) % 8) < cur_density);
    end

    // sampled at the falling edge where valid, byte and stall are settled
    always @(negedge core_clk) begin
        if (sys_reset === 1'b0 && out_valid_o === 1'b1 && out_stall_i === 1'b0) begin
            if (exp_q.size() == 0) begin
                $display("unexpected output byte 0x%02h at %0t ns, nothing was predicted",
                         out_byte_o, $time);
                stop_with_failure();
            end else begin
                check_byte(out_byte_o, exp_q.pop_front(), $sformatf("byte %0d", bytes_seen));
                bytes_seen++;
            end
        end
    end

    initial begin
        sys_reset    = 1'b1;
        host_byte_i  = '0;
        host_valid_i = 1'b0;
        pix_i        = '0;
        pix_valid_i  = 1'b0;
        pix_sof_i    = 1'b0;
        // reset corner at col 4 and row 3
        model_col = RESET_COL;
        model_row = RESET_ROW;
        $readmemh("bench/cam_stream_vectors.mem", vec_mem);

        repeat (RESET_CYCLES) next_cycle();
        sys_reset = 1'b0;
        check_flag(out_valid_o, 1'b0, "out_valid_o after reset");
        check_flag(overflow_o, 1'b0, "overflow_o after reset");

        rec  = 0;
        done = 1'b0;
        while (!done) begin
            if (rec >= MAX_RECORDS) begin
                $display("vectors file has no end record");
                stop_with_failure();
            end else begin
                mode = vec_mem[rec*FIELDS];
                if ($isunknown(mode)) begin
                    $display("vectors file ended without an end record at record %0d", rec);
                    stop_with_failure();
                end else if (mode == MODE_END) begin
                    done = 1'b1;
                end else if (mode != MODE_KEEP && mode != MODE_SET &&
                             mode != MODE_UNKNOWN) begin
                    $display("vectors file has unknown mode %0h at record %0d", mode, rec);
                    stop_with_failure();
                end else begin
                    run_record(mode, vec_mem[rec*FIELDS+1], vec_mem[rec*FIELDS+2],
                               vec_mem[rec*FIELDS+3], vec_mem[rec*FIELDS+4]);
                    rec++;
                end
            end
        end

        // stray bytes after the last frame would show up here
        repeat (IDLE_CYCLES) next_cycle();
        check_flag(overflow_o, overflow_seen, "overflow at end of run");

        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire

// File: bench/cam_stream_vectors.mem
// mode col row seed density, all hex, one record per line
// mode 0 keeps the corner, 1 sets it, 2 sends an unknown address, f ends
// default corner, no commands
0 0004 0003 0000 0
// corner moves
1 0000 0000 0011 0
1 0008 0006 0022 0
// unknown address, window stays at 8,6
2 0002 0001 0022 0
// random stall
1 0003 0005 0033 2
1 0007 0002 0044 4
1 0001 0004 0055 6
1 0005 0000 0066 5
2 0000 0000 0077 3
1 0004 0003 0088 6
// output held for two frames, FIFO overflows
1 0002 0002 0099 8
f 0000 0000 0000 0

// File: cam_stream.f
+incdir+hdl
hdl/cmd_pkg.sv
hdl/pix_pkg.sv
hdl/pixel_stream_if.sv
hdl/host_word_assembler.sv
hdl/roi_regfile.sv
hdl/roi_crop.sv
hdl/frame_serializer.sv
hdl/cam_stream_top.sv
bench/cam_stream_properties.sv
bench/cam_stream_tb.sv

// File: hdl/cam_stream_config.svh
`ifndef CAM_STREAM_CONFIG_SVH
`define CAM_STREAM_CONFIG_SVH

// raw sensor frame in pixels
`define CFG_RAW_WIDTH 16
`define CFG_RAW_HEIGHT 12

// cropped window sent to the host
`define CFG_ROI_WIDTH 8
`define CFG_ROI_HEIGHT 6

// serializer buffer entries
`define CFG_FIFO_DEPTH 64

// "BIVFRAME" with the most significant byte sent first
`define CFG_MAGIC_NUM 64'h42_49_56_46_52_41_4D_45

// host command addresses
`define CFG_ADDR_ROI_COL 16'h0010
`define CFG_ADDR_ROI_ROW 16'h0011

`endif

// File: hdl/cam_stream_top.sv
`timescale 1ns/1ps
`default_nettype none

module cam_stream_top (
    input  logic                core_clk,
    input  logic                sys_reset,
    input  cmd_pkg::host_byte_t host_byte_i,
    input  logic                host_valid_i,
    input  pix_pkg::pixel_t     pix_i,
    input  logic                pix_valid_i,
    input  logic                pix_sof_i,
    input  logic                out_stall_i,
    output cmd_pkg::host_byte_t out_byte_o,
    output logic                out_valid_o,
    output logic                overflow_o
);
    import cmd_pkg::*;
    import pix_pkg::*;

    cmd_word_t   cmd_word;
    logic        cmd_valid;
    roi_corner_t corner;

    // cropped pixels into the serializer
    pixel_stream_if crop_bus ();

    ////////////////////////////////////////////////////////////////////////////
    // host command path

    host_word_assembler u_host_word_assembler (
        .core_clk    (core_clk),
        .sys_reset   (sys_reset),
        .byte_i      (host_byte_i),
        .byte_valid_i(host_valid_i),
        .word_o      (cmd_word),
        .word_valid_o(cmd_valid)
    );

    roi_regfile u_roi_regfile (
        .core_clk    (core_clk),
        .sys_reset   (sys_reset),
        .word_i      (cmd_word),
        .word_valid_i(cmd_valid),
        .corner_o    (corner)
    );

    ////////////////////////////////////////////////////////////////////////////
    // pixel path

    roi_crop u_roi_crop (
        .core_clk (core_clk),
        .sys_reset(sys_reset),
        .pix_i    (pix_i),
        .valid_i  (pix_valid_i),
        .sof_i    (pix_sof_i),
        .corner_i (corner),
        .crop     (crop_bus.source)
    );

    frame_serializer u_frame_serializer (
        .core_clk  (core_clk),
        .sys_reset (sys_reset),
        .crop      (crop_bus.sink),
        .stall_i   (out_stall_i),
        .byte_o    (out_byte_o),
        .valid_o   (out_valid_o),
        .overflow_o(overflow_o)
    );

endmodule

`default_nettype wire

// File: hdl/cmd_pkg.sv
`default_nettype none

package cmd_pkg;

    // one byte on the host link
    typedef logic [7:0] host_byte_t;

    typedef logic [15:0] cmd_addr_t;
    typedef logic [31:0] cmd_data_t;

    // address sits above data in the 48-bit word
    typedef struct packed {
        cmd_addr_t addr;
        cmd_data_t data;
    } cmd_fields_t;

    // bytes[5] is the first byte received
    typedef union packed {
        host_byte_t [5:0] bytes;
        cmd_fields_t      fields;
    } cmd_word_t;

endpackage

`default_nettype wire

// File: hdl/frame_serializer.sv
`timescale 1ns/1ps
`default_nettype none

`include "cam_stream_config.svh"

module frame_serializer (
    input  logic                core_clk,
    input  logic                sys_reset,
    pixel_stream_if.sink        crop,
    input  logic                stall_i,
    output cmd_pkg::host_byte_t byte_o,
    output logic                valid_o,
    output logic                overflow_o
);
    import pix_pkg::*;
    import cmd_pkg::*;

    localparam int unsigned DEPTH = `CFG_FIFO_DEPTH;
    localparam int unsigned AW    = $clog2(DEPTH);

    localparam host_byte_t [7:0] MAGIC_BYTES = `CFG_MAGIC_NUM;
    localparam logic [2:0]       HDR_LAST    = 3'd7;

    localparam logic ST_PIX = 1'b0;
    localparam logic ST_HDR = 1'b1;

    pixel_t     mem_pix [DEPTH];
    logic       mem_sof [DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic       full;
    logic       empty;
    logic       push;
    logic       pop;
    logic       xfer;
    logic       need_hdr;
    logic       state;
    logic       hdr_sent;
    logic [2:0] hdr_idx;

    ////////////////////////////////////////////////////////////////////////////
    // pixel FIFO

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]) && (wr_ptr[AW] != rd_ptr[AW]);
    assign push  = crop.valid && !full;

    always_ff @(posedge core_clk) begin
        if (push) begin
            mem_pix[wr_ptr[AW-1:0]] <= crop.pix;
            mem_sof[wr_ptr[AW-1:0]] <= crop.sof;
        end
    end

    // input is never stalled so a pixel arriving when full is lost
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (crop.valid && full) begin
                overflow_o <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output FSM

    // head opens a frame and its header is still owed
    assign need_hdr = !empty && mem_sof[rd_ptr[AW-1:0]] && !hdr_sent;

    // output depends on registered state only and holds while stalled
    always_comb begin
        if (state == ST_HDR) begin
            valid_o = 1'b1;
            byte_o  = MAGIC_BYTES[HDR_LAST - hdr_idx];
        end else begin
            valid_o = !empty && !need_hdr;
            byte_o  = mem_pix[rd_ptr[AW-1:0]];
        end
    end

    assign xfer = valid_o && !stall_i;
    assign pop  = xfer && (state == ST_PIX);

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            state    <= ST_PIX;
            hdr_sent <= 1'b0;
            hdr_idx  <= '0;
        end else if (state == ST_PIX) begin
            if (need_hdr) begin
                state   <= ST_HDR;
                hdr_idx <= '0;
            end else if (pop) begin
                hdr_sent <= 1'b0;
            end
        end else if (xfer) begin
            hdr_idx <= hdr_idx + 3'd1;
            if (hdr_idx == HDR_LAST) begin
                state    <= ST_PIX;
                hdr_sent <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/host_word_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module host_word_assembler (
    input  logic                core_clk,
    input  logic                sys_reset,
    input  cmd_pkg::host_byte_t byte_i,
    input  logic                byte_valid_i,
    output cmd_pkg::cmd_word_t  word_o,
    output logic                word_valid_o
);
    import cmd_pkg::*;

    localparam int unsigned WORD_BYTES = $bits(cmd_word_t) / $bits(host_byte_t);

    logic [2:0] byte_cnt;

    // first byte ends up in the top slot after six shifts
    always_ff @(posedge core_clk) begin
        if (byte_valid_i) begin
            word_o.bytes <= {word_o.bytes[WORD_BYTES-2:0], byte_i};
        end
    end

    // byte counter wraps and the next byte opens a new word
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            byte_cnt     <= '0;
            word_valid_o <= 1'b0;
        end else begin
            word_valid_o <= 1'b0;
            if (byte_valid_i) begin
                if (byte_cnt == 3'(WORD_BYTES - 1)) begin
                    byte_cnt     <= '0;
                    word_valid_o <= 1'b1;
                end else begin
                    byte_cnt <= byte_cnt + 3'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/pix_pkg.sv
`default_nettype none

package pix_pkg;

    typedef logic [7:0] pixel_t;

    // column or row index
    typedef logic [15:0] coord_t;

    // top left corner of the crop window
    typedef struct packed {
        coord_t col;
        coord_t row;
    } roi_corner_t;

endpackage

`default_nettype wire

// File: hdl/pixel_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

// pixel with its position and one transfer per valid cycle
interface pixel_stream_if;
    import pix_pkg::*;

    pixel_t pix;
    logic   valid;
    logic   sof;
    coord_t col;
    coord_t row;

    modport source (output pix, output valid, output sof, output col, output row);
    modport sink (input pix, input valid, input sof, input col, input row);

endinterface

`default_nettype wire

// File: hdl/roi_crop.sv
`timescale 1ns/1ps
`default_nettype none

`include "cam_stream_config.svh"

module roi_crop (
    input  logic                 core_clk,
    input  logic                 sys_reset,
    input  pix_pkg::pixel_t      pix_i,
    input  logic                 valid_i,
    input  logic                 sof_i,
    input  pix_pkg::roi_corner_t corner_i,
    pixel_stream_if.source       crop
);
    import pix_pkg::*;

    localparam coord_t RAW_W = coord_t'(`CFG_RAW_WIDTH);
    localparam coord_t RAW_H = coord_t'(`CFG_RAW_HEIGHT);
    localparam coord_t ROI_W = coord_t'(`CFG_ROI_WIDTH);
    localparam coord_t ROI_H = coord_t'(`CFG_ROI_HEIGHT);

    pixel_stream_if raw_pos ();

    coord_t      col_cnt;
    coord_t      row_cnt;
    logic        start;
    roi_corner_t corner_q;
    roi_corner_t corner_cur;
    coord_t      rel_col;
    coord_t      rel_row;
    logic        in_win;

    ////////////////////////////////////////////////////////////////////////////
    // position tracking

    assign start = valid_i && sof_i;

    // counters hold the position of the next pixel
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (start) begin
            col_cnt <= coord_t'(1);
            row_cnt <= '0;
        end else if (valid_i) begin
            if (col_cnt == RAW_W - 1) begin
                col_cnt <= '0;
                row_cnt <= (row_cnt == RAW_H - 1) ? '0 : row_cnt + 1;
            end else begin
                col_cnt <= col_cnt + 1;
            end
        end
    end

    assign raw_pos.pix   = pix_i;
    assign raw_pos.valid = valid_i;
    assign raw_pos.sof   = sof_i;
    assign raw_pos.col   = start ? '0 : col_cnt;
    assign raw_pos.row   = start ? '0 : row_cnt;

    ////////////////////////////////////////////////////////////////////////////
    // window

    // corner is frozen for the whole frame at sof
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            corner_q <= '0;
        end else if (raw_pos.valid && raw_pos.sof) begin
            corner_q <= corner_i;
        end
    end

    assign corner_cur = (raw_pos.valid && raw_pos.sof) ? corner_i : corner_q;
    assign rel_col    = raw_pos.col - corner_cur.col;
    assign rel_row    = raw_pos.row - corner_cur.row;

    assign in_win = raw_pos.valid
                 && (raw_pos.col >= corner_cur.col) && (rel_col < ROI_W)
                 && (raw_pos.row >= corner_cur.row) && (rel_row < ROI_H);

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            crop.valid <= 1'b0;
            crop.sof   <= 1'b0;
        end else begin
            crop.valid <= in_win;
            crop.sof   <= in_win && (rel_col == '0) && (rel_row == '0);
        end
    end

    // payload qualified by crop.valid
    always_ff @(posedge core_clk) begin
        crop.pix <= raw_pos.pix;
        crop.col <= rel_col;
        crop.row <= rel_row;
    end

endmodule

`default_nettype wire

// File: hdl/roi_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "cam_stream_config.svh"

module roi_regfile (
    input  logic                 core_clk,
    input  logic                 sys_reset,
    input  cmd_pkg::cmd_word_t   word_i,
    input  logic                 word_valid_i,
    output pix_pkg::roi_corner_t corner_o
);
    import pix_pkg::*;

    // default corner centers the window in the raw frame
    localparam coord_t DEF_COL = coord_t'((`CFG_RAW_WIDTH - `CFG_ROI_WIDTH) / 2);
    localparam coord_t DEF_ROW = coord_t'((`CFG_RAW_HEIGHT - `CFG_ROI_HEIGHT) / 2);

    // low half of the data word carries the coordinate
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            corner_o.col <= DEF_COL;
            corner_o.row <= DEF_ROW;
        end else if (word_valid_i) begin
            case (word_i.fields.addr)
                `CFG_ADDR_ROI_COL: begin
                    corner_o.col <= word_i.fields.data[15:0];
                end
                `CFG_ADDR_ROI_ROW: begin
                    corner_o.row <= word_i.fields.data[15:0];
                end
                default: begin
                    // unknown addresses are ignored
                end
            endcase
        end
    end

endmodule

`default_nettype wire
